// File: build.f
src/sdcmd_pkg.sv
src/sdcmd_if.sv
src/sdcmd_clkgen.sv
src/sdcmd_crc7.sv
src/sdcmd_req_decode.sv
src/sdcmd_line_engine.sv
src/sdcmd_resp_check.sv
src/sdcmd_top.sv
tests/tb_clock.sv
tests/tb_card_model.sv
tests/tb_sdcmd.sv

// File: tests/sdcmd_golden.txt
# cmd(hex) arg(hex) card_word(hex) card_delay(sclk) fault expected_err
# fault: 0 none, 1 silent, 2 bad transbit, 3 bad stopbit, 4 bad crc
00 00000000 00000000 0 0 0
08 000001aa 000001aa 2 0 0
37 00000000 00000120 0 0 0
29 40ff8000 80ff8000 5 0 0
03 00000000 b368e520 1 0 0
3a 00000000 c0ff8000 3 0 0
07 b3680000 00000700 10 0 0
0d b3680000 00000900 0 1 1
10 00000200 00000900 4 2 2
11 00001000 00000900 0 3 3
12 00002000 00000900 25 4 4
0f b3680000 00000000 0 0 0

// File: tests/tb_sdcmd.sv
//////////////////////////////
// SD command engine testbench
// Replays golden transactions and checks
// frames and responses
//////////////////////////////

module tb_sdcmd;
    timeunit 1ns;
    timeprecision 100ps;
    import sdcmd_pkg::*;

    localparam int SEED = 32'h27ea_5882;
    localparam int WAIT_LIMIT = 4000;

    logic clk;
    logic nrst;
    logic req_valid;
    logic [5:0] req_cmd;
    logic [31:0] req_arg;
    logic busy;
    logic sclk;
    logic cmd_out;
    logic cmd_dir;
    logic cmd_in;
    logic resp_valid;
    logic [5:0] resp_cmd;
    logic [31:0] resp_status;
    logic [15:0] resp_rca;
    logic [2:0] resp_err;
    logic [7:0] card_delay;
    logic [31:0] card_word;
    logic [2:0] card_fault;
    logic card_r3;
    logic [47:0] frame;
    logic [6:0] frame_crc;
    int frame_cnt;
    int errors;
    int checks;
    logic hung;

    tb_clock u_clock (
        .o_clk  (clk),
        .o_nrst (nrst)
    );

    sdcmd_top dut (
        .i_clk         (clk),
        .i_nrst        (nrst),
        .i_req_valid   (req_valid),
        .i_req_cmd     (req_cmd),
        .i_req_arg     (req_arg),
        .o_busy        (busy),
        .o_sclk        (sclk),
        .o_cmd         (cmd_out),
        .o_cmd_dir     (cmd_dir),
        .i_cmd         (cmd_in),
        .o_resp_valid  (resp_valid),
        .o_resp_cmd    (resp_cmd),
        .o_resp_status (resp_status),
        .o_resp_rca    (resp_rca),
        .o_resp_err    (resp_err)
    );

    tb_card_model u_card (
        .i_sclk      (sclk),
        .i_cmd       (cmd_out),
        .i_cmd_dir   (cmd_dir),
        .o_cmd       (cmd_in),
        .i_delay     (card_delay),
        .i_word      (card_word),
        .i_fault     (card_fault),
        .i_r3        (card_r3),
        .o_frame     (frame),
        .o_frame_crc (frame_crc),
        .o_frame_cnt (frame_cnt)
    );

    function automatic resp_kind_t kind_of(input logic [5:0] idx);
        case (idx)
            6'd0, 6'd4, 6'd15: return RESP_NONE;
            6'd41, 6'd58:      return RESP_R3;
            6'd3:              return RESP_R6;
            default:           return RESP_R1;
        endcase
    endfunction

    // Short status bits 15, 14, 13 map to card status bits 23, 22, 19
    function automatic logic [31:0] r6_status(input logic [15:0] s);
        return {8'h00, s[15], s[14], 2'b00, s[13], 6'b000000, s[12:0]};
    endfunction

    // Drive and sample point 10 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic compare_field(input string what, input logic [47:0] got,
                                 input logic [47:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic run_one(input logic [5:0] cmd, input logic [31:0] arg,
                           input logic [31:0] word, input int delay, input int fault,
                           input int exp_err);
        resp_kind_t kind;
        int frames_before;
        int resp_seen;
        int n;
        int gap;
        logic [5:0] got_cmd;
        logic [31:0] got_status;
        logic [15:0] got_rca;
        logic [2:0] got_err;
        kind = kind_of(cmd);
        card_delay = delay;
        card_word = word;
        card_fault = fault;
        card_r3 = (kind == RESP_R3);
        frames_before = frame_cnt;
        resp_seen = 0;
        gap = $urandom_range(8, 1);
        repeat (gap) tick();
        req_valid = 1'b1;
        req_cmd = cmd;
        req_arg = arg;
        tick();
        req_valid = 1'b0;
        n = 0;
        while (!busy && n < 20) begin
            tick();
            n++;
        end
        if (!busy) begin
            $display("Timeout: o_busy never rose for CMD%0d", cmd);
            errors++;
            hung = 1'b1;
            return;
        end
        // A strobe while busy must not start a second frame
        tick();
        req_valid = 1'b1;
        req_cmd = 6'd17;
        req_arg = $urandom;
        tick();
        req_valid = 1'b0;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            if (resp_valid) begin
                resp_seen++;
                got_cmd = resp_cmd;
                got_status = resp_status;
                got_rca = resp_rca;
                got_err = resp_err;
            end
            tick();
            n++;
        end
        if (busy) begin
            $display("Timeout: o_busy never fell for CMD%0d", cmd);
            errors++;
            hung = 1'b1;
            return;
        end
        compare_field("frame count", frame_cnt - frames_before, 1);
        compare_field("frame start bit", frame[47], 0);
        compare_field("frame transmission bit", frame[46], 1);
        compare_field("frame index", frame[45:40], cmd);
        compare_field("frame argument", frame[39:8], arg);
        compare_field("frame crc7", frame[7:1], frame_crc);
        compare_field("frame end bit", frame[0], 1);
        compare_field("response count", resp_seen, (kind == RESP_NONE) ? 0 : 1);
        if (kind != RESP_NONE && resp_seen == 1) begin
            compare_field("response error", got_err, exp_err);
            if (exp_err == ERR_NONE) begin
                compare_field("response index", got_cmd, (kind == RESP_R3) ? 6'h3f : cmd);
                compare_field("response status", got_status,
                              (kind == RESP_R6) ? r6_status(word[15:0]) : word);
                compare_field("response rca", got_rca, (kind == RESP_R6) ? word[31:16] : 0);
            end
        end
    endtask

    initial begin
        string line;
        int fd;
        int n;
        logic [31:0] g_cmd;
        logic [31:0] g_arg;
        logic [31:0] g_word;
        int g_delay;
        int g_fault;
        int g_err;
        errors = 0;
        checks = 0;
        hung = 1'b0;
        req_valid = 1'b0;
        req_cmd = '0;
        req_arg = '0;
        card_delay = '0;
        card_word = '0;
        card_fault = '0;
        card_r3 = 1'b0;
        void'($urandom(SEED));
        fd = $fopen("tests/sdcmd_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/sdcmd_golden.txt");
            errors++;
        end else begin
            n = 0;
            while (!nrst && n < 40) begin
                tick();
                n++;
            end
            if (!nrst) begin
                $display("Timeout: reset was never released");
                errors++;
                hung = 1'b1;
            end
            while (!hung && !$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%h %h %h %d %d %d", g_cmd, g_arg, g_word, g_delay,
                                g_fault, g_err) == 6) begin
                        run_one(g_cmd[5:0], g_arg, g_word, g_delay, g_fault, g_err);
                    end
                end
            end
            $fclose(fd);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tests/tb_card_model.sv
//////////////////////////////
// Behavioural SD card
// Captures command frames on CMD and
// answers with a 48-bit response
//////////////////////////////

module tb_card_model (
    input  logic        i_sclk,
    input  logic        i_cmd,
    input  logic        i_cmd_dir,
    output logic        o_cmd,
    input  logic [7:0]  i_delay,
    input  logic [31:0] i_word,
    input  logic [2:0]  i_fault,
    input  logic        i_r3,
    output logic [47:0] o_frame,
    output logic [6:0]  o_frame_crc,
    output int          o_frame_cnt
);
    timeunit 1ns;
    timeprecision 100ps;

    logic capturing;
    int nbits;
    logic [47:0] shift;
    logic armed;
    logic [7:0] gap;
    int left;
    logic [47:0] tx;
    logic [5:0] idx;
    logic [6:0] crc;

    // CRC7 over x^7 + x^3 + 1 taken MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] c;
        logic fb;
        int i;
        c = '0;
        for (i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    initial begin
        o_cmd = 1'b1;
        capturing = 1'b0;
        armed = 1'b0;
        nbits = 0;
        o_frame = '0;
        o_frame_crc = '0;
        o_frame_cnt = 0;
    end

    // Host bits are stable at the rising sclk edge
    always @(posedge i_sclk) begin
        if (!capturing) begin
            if (i_cmd_dir == 1'b0 && i_cmd == 1'b0) begin
                capturing = 1'b1;
                shift = 48'h0;
                nbits = 1;
            end
        end else begin
            shift = {shift[46:0], i_cmd};
            nbits = nbits + 1;
            if (nbits == 48) begin
                capturing = 1'b0;
                o_frame = shift;
                o_frame_crc = crc7_of(shift[47:8]);
                o_frame_cnt = o_frame_cnt + 1;
                // Fault code 1 is silent, 2 bad transbit, 3 bad stopbit and 4 bad crc
                idx = i_r3 ? 6'h3f : shift[45:40];
                crc = i_r3 ? 7'h7f : crc7_of({2'b00, idx, i_word});
                if (i_fault == 3'd4) begin
                    crc = crc ^ 7'h01;
                end
                tx = {1'b0, i_fault == 3'd2, idx, i_word, crc, i_fault != 3'd3};
                armed = (i_fault != 3'd1);
                gap = i_delay;
                left = 48;
            end
        end
    end

    // Card drives on falling edges once the host has released the line
    always @(negedge i_sclk) begin
        if (armed && i_cmd_dir) begin
            if (gap != 0) begin
                gap = gap - 1'b1;
            end else if (left != 0) begin
                o_cmd = tx[47];
                tx = {tx[46:0], 1'b1};
                left = left - 1;
            end else begin
                o_cmd = 1'b1;
                armed = 1'b0;
            end
        end
    end

endmodule

// File: tests/tb_clock.sv
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

module tb_clock (
    output logic o_clk,
    output logic o_nrst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        o_nrst = 1'b0;
        repeat (16) @(posedge o_clk);
        #10;
        o_nrst = 1'b1;
    end

    // 100 ns period
    always #50 o_clk = ~o_clk;

endmodule

// File: src/sdcmd_top.sv
//////////////////////////////
// SD host command engine top
//////////////////////////////

module sdcmd_top (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  logic [5:0]  i_req_cmd,
    input  logic [31:0] i_req_arg,
    output logic        o_busy,
    output logic        o_sclk,
    output logic        o_cmd,
    output logic        o_cmd_dir,
    input  logic        i_cmd,
    output logic        o_resp_valid,
    output logic [5:0]  o_resp_cmd,
    output logic [31:0] o_resp_status,
    output logic [15:0] o_resp_rca,
    output logic [2:0]  o_resp_err
);

    logic sclk_pos;
    logic sclk_neg;

    sdcmd_req_if req_bus ();
    sdcmd_resp_if resp_bus ();

    sdcmd_clkgen u_clkgen (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .o_sclk     (o_sclk),
        .o_sclk_pos (sclk_pos),
        .o_sclk_neg (sclk_neg)
    );

    sdcmd_req_decode u_decode (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req_valid (i_req_valid),
        .i_req_cmd   (i_req_cmd),
        .i_req_arg   (i_req_arg),
        .req         (req_bus.req),
        .o_busy      (o_busy)
    );

    sdcmd_line_engine u_engine (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_sclk_pos (sclk_pos),
        .i_sclk_neg (sclk_neg),
        .i_cmd      (i_cmd),
        .o_cmd      (o_cmd),
        .o_cmd_dir  (o_cmd_dir),
        .req        (req_bus.engine),
        .resp       (resp_bus.source)
    );

    sdcmd_resp_check u_check (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .resp          (resp_bus.sink),
        .o_resp_valid  (o_resp_valid),
        .o_resp_cmd    (o_resp_cmd),
        .o_resp_status (o_resp_status),
        .o_resp_rca    (o_resp_rca),
        .o_resp_err    (o_resp_err)
    );

endmodule

// File: src/sdcmd_resp_check.sv
//////////////////////////////
// Response checker
// Grades the response and splits its fields
//////////////////////////////

module sdcmd_resp_check (
    input  logic               i_clk,
    input  logic               i_nrst,
    sdcmd_resp_if.sink         resp,
    output logic               o_resp_valid,
    output logic [5:0]         o_resp_cmd,
    output logic [31:0]        o_resp_status,
    output logic [15:0]        o_resp_rca,
    output sdcmd_pkg::cmd_err_t o_resp_err
);
    import sdcmd_pkg::*;

    cmd_err_t err;
    logic [31:0] status;
    logic [15:0] rca;

    always_comb begin
        if (resp.timeout) begin
            err = ERR_NO_RESPONSE;
        end else if (!resp.transbit_ok) begin
            err = ERR_TRANSBIT;
        end else if (!resp.stopbit_ok) begin
            err = ERR_STOPBIT;
        end else if (resp.kind != RESP_R3 && resp.crc_rx != resp.crc_calc) begin
            // R3 carries all ones in place of a CRC
            err = ERR_CRC;
        end else begin
            err = ERR_NONE;
        end

        rca = '0;
        status = resp.word.status;
        if (resp.kind == RESP_R6) begin
            // Short status bits go back to their card status slots
            rca = resp.word.r6.rca;
            status = '0;
            status[23] = resp.word.r6.sstat[15];
            status[22] = resp.word.r6.sstat[14];
            status[19] = resp.word.r6.sstat[13];
            status[12:0] = resp.word.r6.sstat[12:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= resp.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (resp.valid) begin
            o_resp_cmd <= resp.cmd;
            o_resp_status <= status;
            o_resp_rca <= rca;
            o_resp_err <= err;
        end
    end

endmodule

// File: src/sdcmd_line_engine.sv
//////////////////////////////
// CMD line engine
// Sends the 48-bit command frame, turns the line
// and shifts in a 48-bit response
//////////////////////////////

module sdcmd_line_engine (
    input  logic         i_clk,
    input  logic         i_nrst,
    input  logic         i_sclk_pos,
    input  logic         i_sclk_neg,
    input  logic         i_cmd,
    output logic         o_cmd,
    output logic         o_cmd_dir,
    sdcmd_req_if.engine  req,
    sdcmd_resp_if.source resp
);
    import sdcmd_pkg::*;

    line_state_t state;
    resp_kind_t kind;
    logic [6:0] cnt;
    logic [39:0] tx_shift;
    logic [5:0] mirror;
    resp_word_u rx_word;
    logic [6:0] crc_rx;
    logic [6:0] crc_calc;
    logic [6:0] crc;
    logic transbit_ok;
    logic stopbit_ok;
    logic rx_phase;
    logic crc_clear;
    logic crc_step;
    logic crc_bit;

    assign rx_phase = state inside {RESP_WAIT, RESP_TRANSBIT, RESP_MIRROR, RESP_REG,
                                    RESP_CRC7, RESP_STOPBIT};

    // CRC covers the 40 frame bits out, then the 40 response bits in
    always_comb begin
        crc_clear = (state == IDLE) || (state == REQ_STOPBIT && i_sclk_neg);
        crc_step = 1'b0;
        crc_bit = i_cmd;
        if (state == REQ_CONTENT) begin
            crc_step = i_sclk_neg;
            crc_bit = tx_shift[39];
        end else if ((state inside {RESP_TRANSBIT, RESP_MIRROR, RESP_REG})
                || (state == RESP_WAIT && !i_cmd)) begin
            crc_step = i_sclk_pos;
        end
    end

    sdcmd_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_step  (crc_step),
        .i_bit   (crc_bit),
        .o_crc   (crc)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= IDLE;
            cnt <= '0;
            o_cmd <= 1'b1;
            o_cmd_dir <= DIR_OUT;
            req.take <= 1'b0;
            req.done <= 1'b0;
            resp.valid <= 1'b0;
            resp.timeout <= 1'b0;
        end else begin
            req.take <= 1'b0;
            req.done <= 1'b0;
            resp.valid <= 1'b0;
            // Line turns around one sclk period after the end bit
            if (i_sclk_neg) begin
                o_cmd_dir <= rx_phase ? DIR_IN : DIR_OUT;
            end
            case (state)
                IDLE: begin
                    if (req.valid) begin
                        req.take <= 1'b1;
                        resp.timeout <= 1'b0;
                        cnt <= 7'd39;
                        state <= REQ_CONTENT;
                    end
                end
                REQ_CONTENT: begin
                    if (i_sclk_neg) begin
                        o_cmd <= tx_shift[39];
                        cnt <= cnt - 1'b1;
                        if (cnt == '0) begin
                            cnt <= 7'd6;
                            state <= REQ_CRC7;
                        end
                    end
                end
                REQ_CRC7: begin
                    if (i_sclk_neg) begin
                        o_cmd <= crc[cnt[2:0]];
                        cnt <= cnt - 1'b1;
                        if (cnt == '0) begin
                            state <= REQ_STOPBIT;
                        end
                    end
                end
                REQ_STOPBIT: begin
                    if (i_sclk_neg) begin
                        o_cmd <= 1'b1;
                        if (kind == RESP_NONE) begin
                            cnt <= 7'(TURN_GAP - 1);
                            state <= PAUSE;
                        end else begin
                            cnt <= 7'(RESP_TIMEOUT - 1);
                            state <= RESP_WAIT;
                        end
                    end
                end
                RESP_WAIT: begin
                    if (i_sclk_pos) begin
                        cnt <= cnt - 1'b1;
                        if (!i_cmd) begin
                            state <= RESP_TRANSBIT;
                        end else if (cnt == '0) begin
                            resp.timeout <= 1'b1;
                            resp.valid <= 1'b1;
                            cnt <= 7'(TURN_GAP - 1);
                            state <= PAUSE;
                        end
                    end
                end
                RESP_TRANSBIT: begin
                    if (i_sclk_pos) begin
                        cnt <= 7'd5;
                        state <= RESP_MIRROR;
                    end
                end
                RESP_MIRROR, RESP_REG, RESP_CRC7: begin
                    if (i_sclk_pos) begin
                        cnt <= cnt - 1'b1;
                        if (cnt == '0 && state == RESP_MIRROR) begin
                            cnt <= 7'd31;
                            state <= RESP_REG;
                        end else if (cnt == '0 && state == RESP_REG) begin
                            cnt <= 7'd6;
                            state <= RESP_CRC7;
                        end else if (cnt == '0) begin
                            state <= RESP_STOPBIT;
                        end
                    end
                end
                RESP_STOPBIT: begin
                    if (i_sclk_pos) begin
                        resp.valid <= 1'b1;
                        cnt <= 7'(TURN_GAP - 1);
                        state <= PAUSE;
                    end
                end
                PAUSE: begin
                    if (i_sclk_pos) begin
                        cnt <= cnt - 1'b1;
                        if (cnt == '0) begin
                            req.done <= 1'b1;
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Frame and response payload
    always_ff @(posedge i_clk) begin
        if (state == IDLE && req.valid) begin
            tx_shift <= {2'b01, req.cmd, req.arg};
            kind <= req.kind;
        end else if (state == REQ_CONTENT && i_sclk_neg) begin
            tx_shift <= {tx_shift[38:0], 1'b1};
        end
        if (i_sclk_pos) begin
            case (state)
                RESP_TRANSBIT: transbit_ok <= !i_cmd;
                RESP_MIRROR:   mirror <= {mirror[4:0], i_cmd};
                RESP_REG:      rx_word.status <= {rx_word.status[30:0], i_cmd};
                RESP_CRC7:     crc_rx <= {crc_rx[5:0], i_cmd};
                RESP_STOPBIT: begin
                    stopbit_ok <= i_cmd;
                    crc_calc <= crc;
                end
                default: ;
            endcase
        end
    end

    assign resp.kind = kind;
    assign resp.cmd = mirror;
    assign resp.word = rx_word;
    assign resp.crc_rx = crc_rx;
    assign resp.crc_calc = crc_calc;
    assign resp.transbit_ok = transbit_ok;
    assign resp.stopbit_ok = stopbit_ok;

    a_dir_out_tx: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (state inside {REQ_CONTENT, REQ_CRC7, REQ_STOPBIT}) |-> (o_cmd_dir == DIR_OUT));

endmodule

// File: src/sdcmd_req_decode.sv
//////////////////////////////
// Host request decoder
// Latches a request, classifies its response
// and tracks the busy flag
//////////////////////////////

module sdcmd_req_decode (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  logic [5:0]  i_req_cmd,
    input  logic [31:0] i_req_arg,
    sdcmd_req_if.req    req,
    output logic        o_busy
);
    import sdcmd_pkg::*;

    logic accept;
    resp_kind_t kind_next;

    // Strobes seen while busy are dropped
    assign accept = i_req_valid && !o_busy;

    always_comb begin
        case (i_req_cmd)
            6'd0, 6'd4, 6'd15: kind_next = RESP_NONE;
            6'd41, 6'd58:      kind_next = RESP_R3;
            6'd3:              kind_next = RESP_R6;
            default:           kind_next = RESP_R1;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            req.valid <= 1'b0;
            o_busy <= 1'b0;
        end else if (accept) begin
            req.valid <= 1'b1;
            o_busy <= 1'b1;
        end else begin
            if (req.take) begin
                req.valid <= 1'b0;
            end
            if (req.done) begin
                o_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            req.cmd <= i_req_cmd;
            req.arg <= i_req_arg;
            req.kind <= kind_next;
        end
    end

    a_take_pending: assert property (@(posedge i_clk) disable iff (!i_nrst)
        req.take |-> req.valid);

endmodule

// File: src/sdcmd_crc7.sv
//////////////////////////////
// Serial CRC7 over x^7 + x^3 + 1
//////////////////////////////

module sdcmd_crc7 (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_clear,
    input  logic       i_step,
    input  logic       i_bit,
    output logic [6:0] o_crc
);

    logic fb;

    assign fb = i_bit ^ o_crc[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_crc <= '0;
        end else if (i_clear) begin
            o_crc <= '0;
        end else if (i_step) begin
            // Feedback enters at taps 3 and 0
            o_crc <= {o_crc[5:3], o_crc[2] ^ fb, o_crc[1:0], fb};
        end
    end

endmodule

// File: src/sdcmd_clkgen.sv
//////////////////////////////
// SD clock divider
// Makes sclk and its edge strobes
//////////////////////////////

module sdcmd_clkgen (
    input  logic i_clk,
    input  logic i_nrst,
    output logic o_sclk,
    output logic o_sclk_pos,
    output logic o_sclk_neg
);
    import sdcmd_pkg::*;

    logic [SCLK_CNT_W-1:0] cnt;
    logic half_done;

    assign half_done = (cnt == SCLK_CNT_W'(SCLK_HALF - 1));

    // Strobe marks the cycle in which sclk has just toggled
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt <= '0;
            o_sclk <= 1'b0;
            o_sclk_pos <= 1'b0;
            o_sclk_neg <= 1'b0;
        end else begin
            o_sclk_pos <= half_done && !o_sclk;
            o_sclk_neg <= half_done && o_sclk;
            if (half_done) begin
                cnt <= '0;
                o_sclk <= ~o_sclk;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    a_one_edge: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_sclk_pos && o_sclk_neg));

endmodule

// File: src/sdcmd_if.sv
//////////////////////////////
// SD command engine internal buses
// Decoded request and raw response
//////////////////////////////

interface sdcmd_req_if;
    import sdcmd_pkg::*;

    logic valid;
    logic [5:0] cmd;
    logic [31:0] arg;
    resp_kind_t kind;
    logic take;
    logic done;

    modport req (output valid, cmd, arg, kind, input take, done);
    modport engine (input valid, cmd, arg, kind, output take, done);
endinterface

interface sdcmd_resp_if;
    import sdcmd_pkg::*;

    logic valid;
    resp_kind_t kind;
    logic [5:0] cmd;
    resp_word_u word;
    logic [6:0] crc_rx;
    logic [6:0] crc_calc;
    logic transbit_ok;
    logic stopbit_ok;
    logic timeout;

    modport source (
        output valid, kind, cmd, word, crc_rx, crc_calc, transbit_ok, stopbit_ok, timeout
    );
    modport sink (
        input valid, kind, cmd, word, crc_rx, crc_calc, transbit_ok, stopbit_ok, timeout
    );
endinterface

// File: src/sdcmd_pkg.sv
//////////////////////////////
// SD command engine shared types
// Response kinds, error codes, FSM states,
// timing constants and the response word
//////////////////////////////

package sdcmd_pkg;

    // i_clk cycles per half period of sclk
    localparam int SCLK_HALF = 4;
    localparam int SCLK_CNT_W = $clog2(SCLK_HALF);

    // sclk cycles allowed before the card start bit
    localparam int RESP_TIMEOUT = 64;

    // Idle sclk cycles after each transaction
    localparam int TURN_GAP = 2;

    // Low CMD line direction means the host drives the line
    localparam logic DIR_OUT = 1'b0;
    localparam logic DIR_IN = 1'b1;

    typedef enum logic [1:0] {
        RESP_NONE,
        RESP_R1,
        RESP_R3,
        RESP_R6
    } resp_kind_t;

    // Checker reports transbit, then stopbit, then crc
    typedef enum logic [2:0] {
        ERR_NONE,
        ERR_NO_RESPONSE,
        ERR_TRANSBIT,
        ERR_STOPBIT,
        ERR_CRC
    } cmd_err_t;

    typedef enum logic [3:0] {
        IDLE,
        REQ_CONTENT,
        REQ_CRC7,
        REQ_STOPBIT,
        RESP_WAIT,
        RESP_TRANSBIT,
        RESP_MIRROR,
        RESP_REG,
        RESP_CRC7,
        RESP_STOPBIT,
        PAUSE
    } line_state_t;

    // Card status for R1/R3 or RCA over short status for R6
    typedef union packed {
        logic [31:0] status;
        struct packed {
            logic [15:0] rca;
            logic [15:0] sstat;
        } r6;
    } resp_word_u;

endpackage
